/* logic/swarm_pkg.sv */
package swarm_pkg;

   localparam int N_THREADS         = 8;
   localparam int LOG_N_THREADS     = 3;
   localparam int LOG_CQ_SLICE_SIZE = 4;
   localparam int CQ_SLOTS          = 1 << LOG_CQ_SLICE_SIZE;

   localparam int TS_W       = 32;
   localparam int LOCALE_W   = 32;
   localparam int TTYPE_W    = 4;
   localparam int OBJ_W      = 32;
   localparam int ADDR_W     = 32;
   localparam int FIFO_OCC_W = 8;

   // a memory line holds sixteen objects, each four bytes wide.
   localparam int LINE_W        = 512;
   localparam int LOG_N_LANES   = 4;
   localparam int N_LANES       = 1 << LOG_N_LANES;
   localparam int LOG_OBJ_BYTES = 2;

   localparam logic [TTYPE_W-1:0] TASK_TYPE_UNDO_LOG_RESTORE = 4'hF;

   localparam int REG_ADDR_W = 8;
   localparam int REG_DATA_W = 32;

   localparam logic [REG_ADDR_W-1:0] RW_BASE_ADDR                        = 8'h10;
   localparam logic [REG_ADDR_W-1:0] CORE_FIFO_OUT_ALMOST_FULL_THRESHOLD = 8'h14;
   localparam logic [REG_ADDR_W-1:0] CORE_N_DEQUEUES                     = 8'h18;

   // one response word, seen whole or as object lanes.
   // lane k sits at bits 32k upward.
   typedef union packed {
      logic [LINE_W-1:0]               flat;
      logic [N_LANES-1:0][OBJ_W-1:0]   lane;
   } cache_line_u;

endpackage

/* logic/read_rw.sv */
`timescale 1ns/1ps

module read_rw
   import swarm_pkg::*;
(
   input  logic                          clk,
   input  logic                          rstn,

   input  logic                          task_in_valid,
   output logic                          task_in_ready,
   input  logic [TS_W-1:0]               task_ts,
   input  logic [LOCALE_W-1:0]           task_locale,
   input  logic [TTYPE_W-1:0]            task_ttype,
   input  logic                          task_no_read,
   input  logic [LOG_CQ_SLICE_SIZE-1:0]  cq_slot_in,
   input  logic [LOG_N_THREADS-1:0]      thread_id_in,

   input  logic                          gvt_task_slot_valid,
   input  logic [LOG_CQ_SLICE_SIZE-1:0]  gvt_task_slot,

   output logic                          arvalid,
   input  logic                          arready,
   output logic [ADDR_W-1:0]             araddr,
   output logic [LOG_N_THREADS-1:0]      arid,

   input  logic                          rvalid,
   output logic                          rready,
   input  logic [LOG_N_THREADS-1:0]      rid,
   input  logic [LINE_W-1:0]             rdata,

   output logic                          task_out_valid,
   input  logic                          task_out_ready,
   output logic [TS_W-1:0]               out_ts,
   output logic [LOCALE_W-1:0]           out_locale,
   output logic [TTYPE_W-1:0]            out_ttype,
   output logic [LOG_CQ_SLICE_SIZE-1:0]  out_cq_slot,
   output logic [LOG_N_THREADS-1:0]      out_thread,
   output logic [OBJ_W-1:0]              out_object,

   input  logic [FIFO_OCC_W-1:0]         task_out_fifo_occ,

   input  logic [ADDR_W-1:0]             base_rw_addr,
   input  logic [FIFO_OCC_W-1:0]         fifo_thresh,
   input  logic [REG_DATA_W-1:0]         dequeues_remaining,

   input  logic [TS_W-1:0]               tt_ts,
   input  logic [LOCALE_W-1:0]           tt_locale,
   input  logic [TTYPE_W-1:0]            tt_ttype,
   input  logic [LOG_CQ_SLICE_SIZE-1:0]  tt_slot,
   input  logic [OBJ_W-1:0]              undo_word,

   output logic                          deq_fire,
   output logic                          log_wr,
   output logic                          restore_rd
);

   logic                          is_restore;
   logic                          is_local;
   logic                          can_dequeue;
   logic                          out_stall;
   cache_line_u                   rline;

   logic                          pend_valid;
   logic                          pend_restore;
   logic [TS_W-1:0]               pend_ts;
   logic [LOCALE_W-1:0]           pend_locale;
   logic [TTYPE_W-1:0]            pend_ttype;
   logic [LOG_CQ_SLICE_SIZE-1:0]  pend_slot;
   logic [LOG_N_THREADS-1:0]      pend_thread;

   assign is_restore  = (task_ttype == TASK_TYPE_UNDO_LOG_RESTORE);
   assign is_local    = task_no_read | is_restore;
   assign can_dequeue = (dequeues_remaining != '0) &
                        ((task_out_fifo_occ < fifo_thresh) |
                         (gvt_task_slot_valid & (gvt_task_slot == cq_slot_in)));

   // a stalled response must not be displaced by a new local result.
   assign out_stall = rvalid & ~task_out_ready;

   assign araddr = base_rw_addr + (ADDR_W'(task_locale) << LOG_OBJ_BYTES);
   assign arid   = thread_id_in;

   always_comb begin
      arvalid       = 1'b0;
      task_in_ready = 1'b0;
      if (task_in_valid && can_dequeue && !pend_valid) begin
         if (is_local) begin
            task_in_ready = ~out_stall;
         end else begin
            arvalid       = 1'b1;
            task_in_ready = arready; // read tasks leave together with their address.
         end
      end
   end

   assign deq_fire   = task_in_valid & task_in_ready;
   assign restore_rd = deq_fire & is_restore;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         pend_valid <= 1'b0;
      end else if (deq_fire && is_local) begin
         pend_valid <= 1'b1;
      end else if (pend_valid && task_out_ready) begin
         pend_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (deq_fire && is_local) begin
         pend_restore <= is_restore;
         pend_ts      <= task_ts;
         pend_locale  <= task_locale;
         pend_ttype   <= task_ttype;
         pend_slot    <= cq_slot_in;
         pend_thread  <= thread_id_in;
      end
   end

   assign rline.flat = rdata;

   always_comb begin
      task_out_valid = 1'b0;
      rready         = 1'b0;
      if (pend_valid) begin
         task_out_valid = 1'b1;
         out_ts         = pend_ts;
         out_locale     = pend_locale;
         out_ttype      = pend_ttype;
         out_cq_slot    = pend_slot;
         out_thread     = pend_thread;
         out_object     = pend_restore ? undo_word : '0;
      end else begin
         task_out_valid = rvalid;
         rready         = rvalid & task_out_ready;
         out_ts         = tt_ts;
         out_locale     = tt_locale;
         out_ttype      = tt_ttype;
         out_cq_slot    = tt_slot;
         out_thread     = rid;
         out_object     = rline.lane[tt_locale[LOG_N_LANES-1:0]]; // object within the line.
      end
   end

   assign log_wr = task_out_valid & task_out_ready;

   // a read address waiting for arready keeps its value.
   a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
      arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
      else $error("read request changed before it was accepted");

   // the output bundle may only change once it has been taken.
   a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
      task_out_valid && !task_out_ready |=>
         task_out_valid && $stable(out_ts) && $stable(out_locale) &&
         $stable(out_ttype) && $stable(out_cq_slot) && $stable(out_thread) &&
         $stable(out_object))
      else $error("task output changed before it was accepted");

endmodule

/* logic/rw_thread_table.sv */
`timescale 1ns/1ps

module rw_thread_table
   import swarm_pkg::*;
(
   input  logic                          clk,

   input  logic                          deq_fire,
   input  logic [LOG_N_THREADS-1:0]      thread_id_in,
   input  logic [TS_W-1:0]               task_ts,
   input  logic [LOCALE_W-1:0]           task_locale,
   input  logic [TTYPE_W-1:0]            task_ttype,
   input  logic [LOG_CQ_SLICE_SIZE-1:0]  cq_slot_in,

   input  logic [LOG_N_THREADS-1:0]      rid,
   output logic [TS_W-1:0]               tt_ts,
   output logic [LOCALE_W-1:0]           tt_locale,
   output logic [TTYPE_W-1:0]            tt_ttype,
   output logic [LOG_CQ_SLICE_SIZE-1:0]  tt_slot
);

   logic [TS_W-1:0]               ts_mem     [N_THREADS];
   logic [LOCALE_W-1:0]           locale_mem [N_THREADS];
   logic [TTYPE_W-1:0]            ttype_mem  [N_THREADS];
   logic [LOG_CQ_SLICE_SIZE-1:0]  slot_mem   [N_THREADS];

   // each thread has at most one read in flight, so its entry is free on accept.
   always_ff @(posedge clk) begin
      if (deq_fire) begin
         ts_mem[thread_id_in]     <= task_ts;
         locale_mem[thread_id_in] <= task_locale;
         ttype_mem[thread_id_in]  <= task_ttype;
         slot_mem[thread_id_in]   <= cq_slot_in;
      end
   end

   assign tt_ts     = ts_mem[rid];
   assign tt_locale = locale_mem[rid];
   assign tt_ttype  = ttype_mem[rid];
   assign tt_slot   = slot_mem[rid];

endmodule

/* logic/undo_log_store.sv */
`timescale 1ns/1ps

module undo_log_store
   import swarm_pkg::*;
(
   input  logic                          clk,

   input  logic                          log_wr,
   input  logic [LOG_CQ_SLICE_SIZE-1:0]  out_cq_slot,
   input  logic [OBJ_W-1:0]              out_object,

   input  logic                          restore_rd,
   input  logic [LOG_CQ_SLICE_SIZE-1:0]  cq_slot_in,
   output logic [OBJ_W-1:0]              undo_word
);

   logic [OBJ_W-1:0]  undo_mem [CQ_SLOTS];
   logic              wr_hit;

   // an object leaving in the same cycle is newer than the stored one.
   assign wr_hit = log_wr & (out_cq_slot == cq_slot_in);

   always_ff @(posedge clk) begin
      if (log_wr) begin
         undo_mem[out_cq_slot] <= out_object;
      end
   end

   always_ff @(posedge clk) begin
      if (restore_rd) begin
         if (wr_hit) begin
            undo_word <= out_object;
         end else begin
            undo_word <= undo_mem[cq_slot_in]; // ready when the result shows.
         end
      end
   end

endmodule

/* logic/rw_config_regs.sv */
`timescale 1ns/1ps

module rw_config_regs
   import swarm_pkg::*;
(
   input  logic                     clk,
   input  logic                     rstn,

   input  logic                     reg_wvalid,
   input  logic [REG_ADDR_W-1:0]    reg_waddr,
   input  logic [REG_DATA_W-1:0]    reg_wdata,

   input  logic                     reg_arvalid,
   input  logic [REG_ADDR_W-1:0]    reg_araddr,
   output logic                     reg_rvalid,
   output logic [REG_DATA_W-1:0]    reg_rdata,

   input  logic                     deq_fire,

   output logic [ADDR_W-1:0]        base_rw_addr,
   output logic [FIFO_OCC_W-1:0]    fifo_thresh,
   output logic [REG_DATA_W-1:0]    dequeues_remaining
);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         base_rw_addr       <= '0;
         fifo_thresh        <= '1;
         dequeues_remaining <= '1;
      end else if (reg_wvalid) begin
         case (reg_waddr)
            RW_BASE_ADDR: begin
               base_rw_addr <= {reg_wdata[ADDR_W-3:0], 2'b00}; // written in words.
            end
            CORE_FIFO_OUT_ALMOST_FULL_THRESHOLD: begin
               fifo_thresh <= reg_wdata[FIFO_OCC_W-1:0];
            end
            CORE_N_DEQUEUES: begin
               dequeues_remaining <= reg_wdata;
            end
            default: begin
            end
         endcase
      end else if (deq_fire) begin
         dequeues_remaining <= dequeues_remaining - 1'b1; // a write wins over the count.
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_arvalid) begin
         case (reg_araddr)
            RW_BASE_ADDR:                        reg_rdata <= base_rw_addr;
            CORE_FIFO_OUT_ALMOST_FULL_THRESHOLD: reg_rdata <= REG_DATA_W'(fifo_thresh);
            CORE_N_DEQUEUES:                     reg_rdata <= dequeues_remaining;
            default:                             reg_rdata <= '0;
         endcase
      end
   end

   // the budget counter must never wrap below zero.
   a_budget_nonzero: assert property (@(posedge clk) disable iff (!rstn)
      deq_fire |-> (dequeues_remaining != '0))
      else $error("task dequeued with no budget left");

endmodule

/* logic/rw_read_top.sv */
`timescale 1ns/1ps

module rw_read_top
   import swarm_pkg::*;
(
   input  logic                          clk,
   input  logic                          rstn,

   input  logic                          task_in_valid,
   output logic                          task_in_ready,
   input  logic [TS_W-1:0]               task_ts,
   input  logic [LOCALE_W-1:0]           task_locale,
   input  logic [TTYPE_W-1:0]            task_ttype,
   input  logic                          task_no_read,
   input  logic [LOG_CQ_SLICE_SIZE-1:0]  cq_slot_in,
   input  logic [LOG_N_THREADS-1:0]      thread_id_in,

   input  logic                          gvt_task_slot_valid,
   input  logic [LOG_CQ_SLICE_SIZE-1:0]  gvt_task_slot,

   output logic                          arvalid,
   input  logic                          arready,
   output logic [ADDR_W-1:0]             araddr,
   output logic [LOG_N_THREADS-1:0]      arid,

   input  logic                          rvalid,
   output logic                          rready,
   input  logic [LOG_N_THREADS-1:0]      rid,
   input  logic [LINE_W-1:0]             rdata,

   output logic                          task_out_valid,
   input  logic                          task_out_ready,
   output logic [TS_W-1:0]               out_ts,
   output logic [LOCALE_W-1:0]           out_locale,
   output logic [TTYPE_W-1:0]            out_ttype,
   output logic [LOG_CQ_SLICE_SIZE-1:0]  out_cq_slot,
   output logic [LOG_N_THREADS-1:0]      out_thread,
   output logic [OBJ_W-1:0]              out_object,

   input  logic [FIFO_OCC_W-1:0]         task_out_fifo_occ,

   input  logic                          reg_wvalid,
   input  logic [REG_ADDR_W-1:0]         reg_waddr,
   input  logic [REG_DATA_W-1:0]         reg_wdata,
   input  logic                          reg_arvalid,
   input  logic [REG_ADDR_W-1:0]         reg_araddr,
   output logic                          reg_rvalid,
   output logic [REG_DATA_W-1:0]         reg_rdata
);

   logic                          deq_fire;
   logic                          log_wr;
   logic                          restore_rd;
   logic [ADDR_W-1:0]             base_rw_addr;
   logic [FIFO_OCC_W-1:0]         fifo_thresh;
   logic [REG_DATA_W-1:0]         dequeues_remaining;
   logic [TS_W-1:0]               tt_ts;
   logic [LOCALE_W-1:0]           tt_locale;
   logic [TTYPE_W-1:0]            tt_ttype;
   logic [LOG_CQ_SLICE_SIZE-1:0]  tt_slot;
   logic [OBJ_W-1:0]              undo_word;

   read_rw ctrl0 (
      .clk, .rstn,
      .task_in_valid, .task_in_ready, .task_ts, .task_locale, .task_ttype,
      .task_no_read, .cq_slot_in, .thread_id_in,
      .gvt_task_slot_valid, .gvt_task_slot,
      .arvalid, .arready, .araddr, .arid,
      .rvalid, .rready, .rid, .rdata,
      .task_out_valid, .task_out_ready, .out_ts, .out_locale, .out_ttype,
      .out_cq_slot, .out_thread, .out_object,
      .task_out_fifo_occ,
      .base_rw_addr, .fifo_thresh, .dequeues_remaining,
      .tt_ts, .tt_locale, .tt_ttype, .tt_slot, .undo_word,
      .deq_fire, .log_wr, .restore_rd
   );

   rw_thread_table ttab0 (
      .clk,
      .deq_fire, .thread_id_in, .task_ts, .task_locale, .task_ttype, .cq_slot_in,
      .rid, .tt_ts, .tt_locale, .tt_ttype, .tt_slot
   );

   undo_log_store undo0 (
      .clk,
      .log_wr, .out_cq_slot, .out_object,
      .restore_rd, .cq_slot_in, .undo_word
   );

   rw_config_regs regs0 (
      .clk, .rstn,
      .reg_wvalid, .reg_waddr, .reg_wdata,
      .reg_arvalid, .reg_araddr, .reg_rvalid, .reg_rdata,
      .deq_fire,
      .base_rw_addr, .fifo_thresh, .dequeues_remaining
   );

endmodule

/* tb/rw_read_tb.sv */
`timescale 1ns/1ps

module rw_read_tb
   import swarm_pkg::*;
();

   localparam int WAIT_LIMIT = 200;
   localparam int EXP_W      = TS_W + LOCALE_W + TTYPE_W + LOG_CQ_SLICE_SIZE +
                               LOG_N_THREADS + OBJ_W + 1;
   localparam int SLOT_LSB   = OBJ_W + 1 + LOG_N_THREADS;

   logic                          clk = 1'b0;
   logic                          rstn;
   logic                          task_in_valid, task_in_ready, task_no_read;
   logic [TS_W-1:0]               task_ts, out_ts;
   logic [LOCALE_W-1:0]           task_locale, out_locale;
   logic [TTYPE_W-1:0]            task_ttype, out_ttype;
   logic [LOG_CQ_SLICE_SIZE-1:0]  cq_slot_in, gvt_task_slot, out_cq_slot;
   logic [LOG_N_THREADS-1:0]      thread_id_in, arid, rid, out_thread;
   logic                          gvt_task_slot_valid, arvalid, arready, rvalid, rready;
   logic [ADDR_W-1:0]             araddr;
   logic [LINE_W-1:0]             rdata;
   logic                          task_out_valid, task_out_ready;
   logic [OBJ_W-1:0]              out_object;
   logic [FIFO_OCC_W-1:0]         task_out_fifo_occ;
   logic                          reg_wvalid, reg_arvalid, reg_rvalid;
   logic [REG_ADDR_W-1:0]         reg_waddr, reg_araddr;
   logic [REG_DATA_W-1:0]         reg_wdata, reg_rdata;

   integer                        seed = 32'h477b;
   int                            fd, r, cycle, errors, err_mark, n_tests, n_pass;
   int                            acc_count, out_count;
   logic                          ar_seen, stall_out, prev_stall;
   logic [ADDR_W-1:0]             base_model;
   cache_line_u                   mem_line;
   logic [ADDR_W-1:0]             resp_addr;
   logic [ADDR_W+LOG_N_THREADS-1:0] req_q [$];
   int                            req_due [$];
   logic [EXP_W-1:0]              exp_q [$];
   logic [EXP_W-1:0]              e, held;
   logic [OBJ_W-1:0]              undo_obj [CQ_SLOTS];
   logic                          undo_chk [CQ_SLOTS];
   logic [8*8-1:0]                cmd;
   logic [8*160-1:0]              skip_line;
   logic [31:0]                   f [7];

   rw_read_top dut0 (.*);

   always #10 clk = ~clk;

   task automatic check_val(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
      if (act_v !== exp_v) begin
         $display("FAIL %0t %s expected %h got %h", $time, name, exp_v, act_v);
         errors++;
      end
   endtask

   task automatic note_error(input string msg);
      $display("ERROR %0t %s", $time, msg);
      errors++;
   endtask

   task automatic check_bundle(input logic [EXP_W-1:0] x);
      logic [TS_W-1:0]              ts;
      logic [LOCALE_W-1:0]          loc;
      logic [TTYPE_W-1:0]           tt;
      logic [LOG_CQ_SLICE_SIZE-1:0] slot;
      logic [LOG_N_THREADS-1:0]     thr;
      logic [OBJ_W-1:0]             obj;
      logic                         chk;
      {ts, loc, tt, slot, thr, obj, chk} = x;
      check_val("out_ts", ts, out_ts);
      check_val("out_locale", loc, out_locale);
      check_val("out_ttype", tt, out_ttype);
      check_val("out_cq_slot", slot, out_cq_slot);
      check_val("out_thread", thr, out_thread);
      if (chk)
         check_val("out_object", obj, out_object);
   endtask

   // an in-order memory answers each request 1 to 4 cycles after it came.
   always @(posedge clk) begin
      cycle = cycle + 1;
      if (rstn && arvalid && arready) begin
         req_q.push_back({araddr, arid});
         req_due.push_back(cycle + 1 + ($unsigned($random(seed)) % 4));
      end
      if (rstn && rvalid && rready) begin
         void'(req_q.pop_front());
         void'(req_due.pop_front());
      end
   end

   always @(negedge clk) begin
      arready        = ($random(seed) & 3) != 0;
      task_out_ready = !stall_out && (($random(seed) & 3) != 0);
      rvalid         = 1'b0;
      if (req_due.size() > 0 && req_due[0] <= cycle) begin
         resp_addr = req_q[0][ADDR_W+LOG_N_THREADS-1:LOG_N_THREADS] & ~32'h3F; // line start.
         for (int k = 0; k < N_LANES; k++) begin
            mem_line.lane[k] = (resp_addr + 4 * k) ^ 32'hA5A50000;
         end
         rvalid = 1'b1;
         rid    = req_q[0][LOG_N_THREADS-1:0];
         rdata  = mem_line.flat;
      end
   end

   always @(posedge clk) begin
      if (rstn) begin
         if (arvalid)
            ar_seen = 1'b1;
         if (prev_stall) begin
            if (!task_out_valid)
               note_error("task_out_valid dropped before the output was accepted");
            check_bundle(held); // a stalled output must keep every field.
         end
         if (task_out_valid && task_out_ready) begin
            out_count++;
            if (exp_q.size() == 0) begin
               note_error("output seen with no task waiting for it");
            end else begin
               e = exp_q.pop_front();
               check_bundle(e);
               undo_obj[e[SLOT_LSB +: LOG_CQ_SLICE_SIZE]] = e[1 +: OBJ_W];
               undo_chk[e[SLOT_LSB +: LOG_CQ_SLICE_SIZE]] = e[0];
            end
         end
         prev_stall = task_out_valid && !task_out_ready;
         held = {out_ts, out_locale, out_ttype, out_cq_slot, out_thread, out_object, 1'b1};
      end
   end

   task automatic drain();
      int n;
      n = 0;
      while (out_count != acc_count && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (out_count != acc_count)
         note_error("outputs missing, fewer tasks came out than went in");
   endtask

   task automatic send_task(input logic [TS_W-1:0] ts, input logic [LOCALE_W-1:0] loc,
                            input logic [TTYPE_W-1:0] tt, input logic nr,
                            input logic [LOG_CQ_SLICE_SIZE-1:0] slot,
                            input logic [LOG_N_THREADS-1:0] thr, input int outcome);
      int                n;
      logic              acc;
      logic              is_read;
      logic              chk;
      logic [ADDR_W-1:0] addr;
      logic [OBJ_W-1:0]  obj;
      n       = 0;
      acc     = 1'b0;
      is_read = !nr && (tt != TASK_TYPE_UNDO_LOG_RESTORE);
      addr    = base_model + (loc << 2);
      obj     = addr ^ 32'hA5A50000; // the word the memory holds at that address.
      @(negedge clk);
      {task_ts, task_locale, task_ttype, task_no_read} = {ts, loc, tt, nr};
      cq_slot_in    = slot;
      thread_id_in  = thr;
      task_in_valid = 1'b1;
      ar_seen       = 1'b0;
      while (!acc && n < WAIT_LIMIT) begin
         @(posedge clk);
         n++;
         if (task_in_ready) begin
            acc = 1'b1;
            acc_count++;
            chk = is_read;
            if (is_read) begin
               if (!arvalid)
                  note_error("read task accepted without arvalid");
               check_val("araddr", addr, araddr);
               check_val("arid", thr, arid);
            end else if (tt == TASK_TYPE_UNDO_LOG_RESTORE) begin
               obj = undo_obj[slot]; // the last object sent out for this slot.
               chk = undo_chk[slot];
            end
            exp_q.push_back({ts, loc, tt, slot, thr, obj, chk});
         end
      end
      @(negedge clk);
      task_in_valid = 1'b0;
      if (outcome == 0 && acc) begin
         note_error("task accepted although the dequeue rule should block it");
      end else if (outcome != 0 && !acc) begin
         note_error("task not accepted within the wait bound");
      end else if (outcome == 1) begin
         drain();
         if (!is_read && ar_seen)
            note_error("memory request seen for a task without a read");
      end
   endtask

   task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [REG_DATA_W-1:0] data);
      @(negedge clk);
      reg_wvalid = 1'b1;
      reg_waddr  = addr;
      reg_wdata  = data;
      @(negedge clk);
      reg_wvalid = 1'b0;
      if (addr == RW_BASE_ADDR)
         base_model = data << 2; // the base register counts in words.
   endtask

   task automatic reg_read(input logic [REG_ADDR_W-1:0] addr, input logic [REG_DATA_W-1:0] exp_v);
      int n;
      n = 0;
      @(negedge clk);
      reg_arvalid = 1'b1;
      reg_araddr  = addr;
      @(negedge clk);
      reg_arvalid = 1'b0;
      while (!reg_rvalid && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!reg_rvalid) begin
         note_error("register read got no reg_rvalid");
      end else begin
         if (n != 0)
            note_error("reg_rvalid came later than one cycle after reg_arvalid");
         check_val("reg_rdata", exp_v, reg_rdata);
      end
   endtask

   task automatic finish_test(input int num);
      drain();
      n_tests++;
      if (errors == err_mark) begin
         n_pass++;
         $display("test %0d done: ok", num);
      end else begin
         $display("test %0d done: %0d errors", num, errors - err_mark);
      end
      err_mark = errors;
   endtask

   initial begin
      {rstn, task_in_valid, task_no_read, gvt_task_slot_valid, arready, rvalid} = '0;
      {task_ts, task_locale, task_ttype, cq_slot_in, thread_id_in, gvt_task_slot} = '0;
      {rid, rdata, task_out_ready, task_out_fifo_occ} = '0;
      {reg_wvalid, reg_waddr, reg_wdata, reg_arvalid, reg_araddr} = '0;
      {cycle, errors, err_mark, n_tests, n_pass, acc_count, out_count} = '0;
      {ar_seen, stall_out, prev_stall, base_model} = '0;
      foreach (undo_chk[i]) begin
         undo_chk[i] = 1'b0;
         undo_obj[i] = '0;
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      fd = $fopen("tb/rw_read_testdata.txt", "r");
      if (fd == 0)
         note_error("cannot open tb/rw_read_testdata.txt");
      while (fd != 0 && $fscanf(fd, "%s", cmd) == 1) begin
         if (cmd == "#") begin
            r = $fgets(skip_line, fd);
         end else begin
            r = $fscanf(fd, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
            if (r != 7)
               note_error("test data record has missing fields");
            case (cmd)
               "W": reg_write(f[0][REG_ADDR_W-1:0], f[1]);
               "R": reg_read(f[0][REG_ADDR_W-1:0], f[1]);
               "T": send_task(f[0], f[1], f[2][TTYPE_W-1:0], f[3][0],
                              f[4][LOG_CQ_SLICE_SIZE-1:0], f[5][LOG_N_THREADS-1:0], f[6]);
               "O": begin
                  @(negedge clk);
                  task_out_fifo_occ = f[0][FIFO_OCC_W-1:0];
               end
               "G": begin
                  @(negedge clk);
                  gvt_task_slot_valid = f[0][0];
                  gvt_task_slot       = f[1][LOG_CQ_SLICE_SIZE-1:0];
               end
               "S": stall_out = f[0][0];
               "C": repeat (f[0]) @(negedge clk);
               "P": finish_test(f[0]);
               default: note_error("unknown record in the test data file");
            endcase
         end
      end
      if (fd != 0)
         $fclose(fd);
      $display("%0d of %0d tests ok, %0d errors", n_pass, n_tests, errors);
      if (errors == 0 && n_tests > 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* tb/rw_read_testdata.txt */
# each record is a command letter and seven hex fields, unused fields are zero.
# W addr data | R addr expected | T ts locale ttype no_read slot thread outcome
# outcome 0 not accepted, 1 accepted and drained, 2 accepted and left in flight
# O fifo_occ | G gvt_valid gvt_slot | S output_stall | C idle_cycles | P test_number
W 10 100 0 0 0 0 0
T 00001000 25 1 0 2 1 1
T 00001001 7 2 0 4 2 1
P 1 0 0 0 0 0 0
T 00002000 11 3 1 6 4 1
T 00002001 3c 5 1 7 5 1
P 2 0 0 0 0 0 0
T 00003000 9 1 0 3 0 1
T 00003001 9 f 0 3 1 1
T 00003002 2a 2 0 8 6 1
T 00003003 0 f 0 8 7 1
P 3 0 0 0 0 0 0
W 18 2 0 0 0 0 0
T 00004000 12 1 0 8 2 1
T 00004001 13 1 1 9 3 1
T 00004002 14 1 0 a 4 0
R 18 0 0 0 0 0 0
W 18 ffff 0 0 0 0 0
T 00004002 14 1 0 a 4 1
P 4 0 0 0 0 0 0
W 14 4 0 0 0 0 0
O 6 0 0 0 0 0 0
T 00005000 20 2 0 5 1 0
G 1 5 0 0 0 0 0
T 00005000 20 2 0 5 1 1
G 0 0 0 0 0 0 0
O 0 0 0 0 0 0 0
P 5 0 0 0 0 0 0
S 1 0 0 0 0 0 0
T 00006000 30 1 0 b 1 2
T 00006001 31 1 0 c 2 2
T 00006002 42 1 0 d 3 2
C 14 0 0 0 0 0 0
S 0 0 0 0 0 0 0
R 14 4 0 0 0 0 0
R 10 400 0 0 0 0 0
P 6 0 0 0 0 0 0

/* sources.f */
logic/swarm_pkg.sv
logic/read_rw.sv
logic/rw_thread_table.sv
logic/undo_log_store.sv
logic/rw_config_regs.sv
logic/rw_read_top.sv
tb/rw_read_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module rw_read_tb \
   -f sources.f -o rw_read_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/rw_read_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "all tests passed" sim.log && exit 0 || exit 1
